// File: sim.f
source/pinmux_pkg.sv
source/pad_in_sync.sv
source/pinmux_regs.sv
source/tick_gen.sv
source/pwm_gen.sv
source/pad_out_mux.sv
source/pinmux_top.sv
tests/pinmux_asserts.sv
tests/tb_pinmux.sv

// File: source/pad_in_sync.sv
`timescale 1ns/1ps

module pad_in_sync #(
  parameter int NUM_PINS = 16
) (
  input  logic                mclk_i,
  input  logic                rst_n_i,
  input  logic [NUM_PINS-1:0] pad_in_i,
  output logic [NUM_PINS-1:0] pad_sync_o,
  output logic [NUM_PINS-1:0] rise_o,
  output logic [NUM_PINS-1:0] fall_o
);

  // Two-flop synchronizer stages
  logic [NUM_PINS-1:0] sync_q1;
  logic [NUM_PINS-1:0] sync_q2;
  // Previous synchronized sample
  logic [NUM_PINS-1:0] prev_q;
  // Registered edge pulses
  logic [NUM_PINS-1:0] rise_q;
  logic [NUM_PINS-1:0] fall_q;

  // --------------------------------------------------------------------------
  // Pad capture and edge detect
  // --------------------------------------------------------------------------
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      prev_q  <= '0;
      rise_q  <= '0;
      fall_q  <= '0;
    end else begin
      sync_q1 <= pad_in_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
      // One-cycle pulse per synchronized transition
      rise_q  <= sync_q2 & ~prev_q;
      fall_q  <= ~sync_q2 & prev_q;
    end
  end

  // Pad view lags the pin by 2 clocks
  assign pad_sync_o = sync_q2;
  assign rise_o     = rise_q;
  assign fall_o     = fall_q;

endmodule

// File: source/pad_out_mux.sv
`timescale 1ns/1ps

module pad_out_mux #(
  parameter int NUM_PINS = 16,
  parameter int NUM_PWM  = 4
) (
  input  pinmux_pkg::gpio_cfg_t gpio_cfg_i,
  input  logic [NUM_PWM-1:0]    pwm_en_i,
  input  logic [NUM_PWM-1:0]    pwm_wave_i,
  output logic [NUM_PINS-1:0]   pad_out_o,
  output logic [NUM_PINS-1:0]   pad_oen_o
);

  // --------------------------------------------------------------------------
  // Per-pad select, pad k belongs to PWM channel k
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < NUM_PINS; i++) begin : g_pad
    if (i < NUM_PWM) begin : g_pwm_pad
      // PWM first, then GPIO output, else input
      always_comb begin
        if (pwm_en_i[i]) begin
          pad_out_o[i] = pwm_wave_i[i];
          pad_oen_o[i] = 1'b0;
        end else if (gpio_cfg_i.dir[i]) begin
          pad_out_o[i] = gpio_cfg_i.out[i];
          pad_oen_o[i] = 1'b0;
        end else begin
          pad_out_o[i] = 1'b0;
          pad_oen_o[i] = 1'b1;
        end
      end
    end else begin : g_gpio_pad
      // Plain GPIO pad
      always_comb begin
        if (gpio_cfg_i.dir[i]) begin
          pad_out_o[i] = gpio_cfg_i.out[i];
          pad_oen_o[i] = 1'b0;
        end else begin
          pad_out_o[i] = 1'b0;
          pad_oen_o[i] = 1'b1;
        end
      end
    end
  end

endmodule

// File: source/pinmux_pkg.sv
package pinmux_pkg;

  // --------------------------------------------------------------------------
  // Bus and field widths
  // --------------------------------------------------------------------------
  localparam int DATA_W  = 32;
  localparam int ADR_W   = 4;
  localparam int SEL_W   = DATA_W / 8;
  localparam int PWM_W   = 16;
  localparam int PULSE_W = 10;

  // Register word map
  typedef enum logic [ADR_W-1:0] {
    REG_GPIO_DIR  = 4'd0,
    REG_GPIO_OUT  = 4'd1,
    REG_GPIO_IN   = 4'd2,   // read-only pad view
    REG_INT_POS   = 4'd3,
    REG_INT_NEG   = 4'd4,
    REG_INT_STAT  = 4'd5,   // write 1 to clear
    REG_PWM_EN    = 4'd6,
    REG_PULSE_CFG = 4'd7,
    REG_PWM_BASE  = 4'd8    // channel k at 8+k
  } reg_addr_e;

  // --------------------------------------------------------------------------
  // Wishbone classic request and response
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADR_W-1:0]  adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] dat;
    logic              ack;
  } wb_rsp_t;

  // GPIO config at full width, top level takes the low pins
  typedef struct packed {
    logic [DATA_W-1:0] dir;
    logic [DATA_W-1:0] out;
  } gpio_cfg_t;

  // One PWM channel, phase lengths in ms ticks
  typedef struct packed {
    logic [PWM_W-1:0] high;
    logic [PWM_W-1:0] low;
  } pwm_cfg_t;

endpackage

// File: source/pinmux_regs.sv
`timescale 1ns/1ps

module pinmux_regs #(
  parameter int NUM_PINS = 16,
  parameter int NUM_PWM  = 4
) (
  input  logic                             mclk_i,
  input  logic                             rst_n_i,
  input  pinmux_pkg::wb_req_t              wb_i,
  output pinmux_pkg::wb_rsp_t              wb_o,
  input  logic [NUM_PINS-1:0]              pad_sync_i,
  input  logic [NUM_PINS-1:0]              rise_i,
  input  logic [NUM_PINS-1:0]              fall_i,
  output pinmux_pkg::gpio_cfg_t            gpio_cfg_o,
  output logic [NUM_PWM-1:0]               pwm_en_o,
  output logic [pinmux_pkg::PULSE_W-1:0]   pulse_cfg_o,
  output pinmux_pkg::pwm_cfg_t             pwm_cfg_o [NUM_PWM],
  output logic                             irq_o
);

  import pinmux_pkg::*;

  // Register storage
  gpio_cfg_t           gpio_cfg;
  logic [NUM_PINS-1:0] int_pos;
  logic [NUM_PINS-1:0] int_neg;
  logic [NUM_PINS-1:0] int_stat;
  logic [NUM_PWM-1:0]  pwm_en;
  logic [PULSE_W-1:0]  pulse_cfg;
  pwm_cfg_t            pwm_cfg [NUM_PWM];

  // Bus side
  logic                ack_q;
  logic                wr_en;
  logic [DATA_W-1:0]   lane_mask;
  logic [DATA_W-1:0]   rd_data;
  logic [DATA_W-1:0]   wr_data;
  logic [NUM_PINS-1:0] stat_clr;
  logic [NUM_PINS-1:0] edge_set;

  // --------------------------------------------------------------------------
  // Wishbone handshake, fixed one-cycle latency
  // --------------------------------------------------------------------------
  // New request only when ack is not already up
  assign wr_en = wb_i.cyc & wb_i.stb & wb_i.we & ~ack_q;

  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_i.cyc & wb_i.stb & ~ack_q;
    end
  end

  // Byte lanes from sel
  always_comb begin
    for (int b = 0; b < SEL_W; b++) begin
      lane_mask[8*b +: 8] = {8{wb_i.sel[b]}};
    end
  end

  // Read mux, unmapped words read zero
  always_comb begin
    rd_data = '0;
    case (wb_i.adr)
      REG_GPIO_DIR:  rd_data = gpio_cfg.dir;
      REG_GPIO_OUT:  rd_data = gpio_cfg.out;
      REG_GPIO_IN:   rd_data[NUM_PINS-1:0] = pad_sync_i;
      REG_INT_POS:   rd_data[NUM_PINS-1:0] = int_pos;
      REG_INT_NEG:   rd_data[NUM_PINS-1:0] = int_neg;
      REG_INT_STAT:  rd_data[NUM_PINS-1:0] = int_stat;
      REG_PWM_EN:    rd_data[NUM_PWM-1:0] = pwm_en;
      REG_PULSE_CFG: rd_data[PULSE_W-1:0] = pulse_cfg;
      default: begin
        for (int k = 0; k < NUM_PWM; k++) begin
          if (wb_i.adr == ADR_W'(int'(REG_PWM_BASE) + k)) rd_data = pwm_cfg[k];
        end
      end
    endcase
  end

  // Merge of old value and bus data per byte lane
  assign wr_data = (rd_data & ~lane_mask) | (wb_i.dat & lane_mask);

  // --------------------------------------------------------------------------
  // Interrupt status
  // --------------------------------------------------------------------------
  assign edge_set = (rise_i & int_pos) | (fall_i & int_neg);
  assign stat_clr = (wr_en && wb_i.adr == REG_INT_STAT) ?
                    (wb_i.dat[NUM_PINS-1:0] & lane_mask[NUM_PINS-1:0]) : '0;

  // --------------------------------------------------------------------------
  // Register updates
  // --------------------------------------------------------------------------
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_cfg  <= '0;
      int_pos   <= '0;
      int_neg   <= '0;
      int_stat  <= '0;
      pwm_en    <= '0;
      pulse_cfg <= '0;
      for (int k = 0; k < NUM_PWM; k++) begin
        pwm_cfg[k] <= '0;
      end
    end else begin
      // Edge set after clear, so a new edge wins
      int_stat <= (int_stat & ~stat_clr) | edge_set;
      if (wr_en) begin
        case (wb_i.adr)
          REG_GPIO_DIR:  gpio_cfg.dir <= wr_data;
          REG_GPIO_OUT:  gpio_cfg.out <= wr_data;
          REG_INT_POS:   int_pos      <= wr_data[NUM_PINS-1:0];
          REG_INT_NEG:   int_neg      <= wr_data[NUM_PINS-1:0];
          REG_PWM_EN:    pwm_en       <= wr_data[NUM_PWM-1:0];
          REG_PULSE_CFG: pulse_cfg    <= wr_data[PULSE_W-1:0];
          default: begin
            for (int k = 0; k < NUM_PWM; k++) begin
              if (wb_i.adr == ADR_W'(int'(REG_PWM_BASE) + k)) pwm_cfg[k] <= wr_data;
            end
          end
        endcase
      end
    end
  end

  // Outputs
  assign wb_o        = '{dat: rd_data, ack: ack_q};
  assign gpio_cfg_o  = gpio_cfg;
  assign pwm_en_o    = pwm_en;
  assign pulse_cfg_o = pulse_cfg;
  assign pwm_cfg_o   = pwm_cfg;
  // Single irq line for all pins
  assign irq_o       = |int_stat;

endmodule

// File: source/pinmux_top.sv
`timescale 1ns/1ps

module pinmux_top #(
  parameter int NUM_PINS  = 16,
  parameter int NUM_PWM   = 4,
  parameter int US_PER_MS = 1000
) (
  input  logic                mclk_i,
  input  logic                rst_n_i,
  input  pinmux_pkg::wb_req_t wb_i,
  output pinmux_pkg::wb_rsp_t wb_o,
  input  logic [NUM_PINS-1:0] pad_in_i,
  output logic [NUM_PINS-1:0] pad_out_o,
  output logic [NUM_PINS-1:0] pad_oen_o,
  output logic                irq_o
);

  import pinmux_pkg::*;

  // Input side
  logic [NUM_PINS-1:0] pad_sync;
  logic [NUM_PINS-1:0] rise;
  logic [NUM_PINS-1:0] fall;
  // Config from register bank
  gpio_cfg_t           gpio_cfg;
  logic [NUM_PWM-1:0]  pwm_en;
  logic [PULSE_W-1:0]  pulse_cfg;
  pwm_cfg_t            pwm_cfg [NUM_PWM];
  // Timing and waves
  logic                tick_ms;
  logic [NUM_PWM-1:0]  pwm_wave;

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------
  pad_in_sync #(.NUM_PINS(NUM_PINS)) u_pad_in_sync (
    .mclk_i     (mclk_i),
    .rst_n_i    (rst_n_i),
    .pad_in_i   (pad_in_i),
    .pad_sync_o (pad_sync),
    .rise_o     (rise),
    .fall_o     (fall)
  );

  // --------------------------------------------------------------------------
  // Register bank, tick and PWM channels
  // --------------------------------------------------------------------------
  pinmux_regs #(.NUM_PINS(NUM_PINS), .NUM_PWM(NUM_PWM)) u_pinmux_regs (
    .mclk_i      (mclk_i),
    .rst_n_i     (rst_n_i),
    .wb_i        (wb_i),
    .wb_o        (wb_o),
    .pad_sync_i  (pad_sync),
    .rise_i      (rise),
    .fall_i      (fall),
    .gpio_cfg_o  (gpio_cfg),
    .pwm_en_o    (pwm_en),
    .pulse_cfg_o (pulse_cfg),
    .pwm_cfg_o   (pwm_cfg),
    .irq_o       (irq_o)
  );

  tick_gen #(.US_PER_MS(US_PER_MS)) u_tick_gen (
    .mclk_i      (mclk_i),
    .rst_n_i     (rst_n_i),
    .pulse_cfg_i (pulse_cfg),
    .tick_ms_o   (tick_ms)
  );

  for (genvar k = 0; k < NUM_PWM; k++) begin : g_pwm
    pwm_gen u_pwm_gen (
      .mclk_i    (mclk_i),
      .rst_n_i   (rst_n_i),
      .tick_ms_i (tick_ms),
      .enable_i  (pwm_en[k]),
      .cfg_i     (pwm_cfg[k]),
      .wave_o    (pwm_wave[k])
    );
  end

  // --------------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------------
  pad_out_mux #(.NUM_PINS(NUM_PINS), .NUM_PWM(NUM_PWM)) u_pad_out_mux (
    .gpio_cfg_i (gpio_cfg),
    .pwm_en_i   (pwm_en),
    .pwm_wave_i (pwm_wave),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o)
  );

endmodule

// File: source/pwm_gen.sv
`timescale 1ns/1ps

module pwm_gen (
  input  logic                 mclk_i,
  input  logic                 rst_n_i,
  input  logic                 tick_ms_i,
  input  logic                 enable_i,
  input  pinmux_pkg::pwm_cfg_t cfg_i,
  output logic                 wave_o
);

  import pinmux_pkg::*;

  typedef enum logic {
    PH_HIGH,
    PH_LOW
  } phase_e;

  phase_e           phase_q;
  phase_e           phase_d;
  logic [PWM_W-1:0] cnt_q;
  logic [PWM_W-1:0] cnt_d;
  logic [PWM_W-1:0] len;
  logic             wave_q;

  // --------------------------------------------------------------------------
  // Phase counter
  // --------------------------------------------------------------------------
  always_comb begin
    len = (phase_q == PH_HIGH) ? cfg_i.high : cfg_i.low;
    // Zero length behaves as one tick
    if (len == '0) len = PWM_W'(1);
    phase_d = phase_q;
    cnt_d   = cnt_q;
    if (tick_ms_i) begin
      // >= keeps a shortened phase from running past its end
      if (cnt_q >= len - 1'b1) begin
        cnt_d   = '0;
        phase_d = (phase_q == PH_HIGH) ? PH_LOW : PH_HIGH;
      end else begin
        cnt_d = cnt_q + 1'b1;
      end
    end
  end

  // Disabled channel parks in high phase with the pin low
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= PH_HIGH;
      cnt_q   <= '0;
      wave_q  <= 1'b0;
    end else if (!enable_i) begin
      phase_q <= PH_HIGH;
      cnt_q   <= '0;
      wave_q  <= 1'b0;
    end else begin
      phase_q <= phase_d;
      cnt_q   <= cnt_d;
      wave_q  <= (phase_d == PH_HIGH);
    end
  end

  assign wave_o = wave_q;

endmodule

// File: source/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
  parameter int US_PER_MS = 1000
) (
  input  logic                           mclk_i,
  input  logic                           rst_n_i,
  input  logic [pinmux_pkg::PULSE_W-1:0] pulse_cfg_i,
  output logic                           tick_ms_o
);

  import pinmux_pkg::*;

  localparam int MS_W = (US_PER_MS > 1) ? $clog2(US_PER_MS) : 1;

  logic [PULSE_W-1:0] us_cnt;
  logic               tick_us;
  logic [MS_W-1:0]    ms_cnt;
  logic               tick_ms_q;

  // --------------------------------------------------------------------------
  // Microsecond tick, once every pulse_cfg+1 clocks
  // --------------------------------------------------------------------------
  assign tick_us = (us_cnt == '0);

  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      us_cnt <= '0;
    end else if (tick_us) begin
      us_cnt <= pulse_cfg_i;
    end else begin
      us_cnt <= us_cnt - 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Millisecond tick on every US_PER_MS-th us tick
  // --------------------------------------------------------------------------
  always_ff @(posedge mclk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ms_cnt    <= '0;
      tick_ms_q <= 1'b0;
    end else begin
      tick_ms_q <= 1'b0;
      if (tick_us) begin
        if (ms_cnt == MS_W'(US_PER_MS - 1)) begin
          ms_cnt    <= '0;
          tick_ms_q <= 1'b1;
        end else begin
          ms_cnt <= ms_cnt + 1'b1;
        end
      end
    end
  end

  assign tick_ms_o = tick_ms_q;

endmodule

// File: tests/pinmux_asserts.sv
`timescale 1ns/1ps

module pinmux_asserts #(
  parameter int NUM_PINS = 16,
  parameter int NUM_PWM  = 4
) (
  input logic                mclk_i,
  input logic                rst_n_i,
  input pinmux_pkg::wb_req_t wb_i,
  input pinmux_pkg::wb_rsp_t wb_o,
  input logic [NUM_PINS-1:0] pad_oen_i,
  input logic [NUM_PWM-1:0]  pwm_en_i
);

  import pinmux_pkg::*;

  // Failure count, read by the testbench at the end
  int assert_fails = 0;

  // Ack only inside an active cycle
  a_ack_in_cycle: assert property (@(posedge mclk_i) disable iff (!rst_n_i)
    wb_o.ack |-> (wb_i.cyc && wb_i.stb))
  else begin
    $error("ack raised without cyc and stb");
    assert_fails++;
  end

  // Ack is a single-cycle pulse
  a_ack_single: assert property (@(posedge mclk_i) disable iff (!rst_n_i)
    wb_o.ack |=> !wb_o.ack)
  else begin
    $error("ack high on two cycles in a row");
    assert_fails++;
  end

  // PWM pads drive while their channel runs
  a_pwm_oen: assert property (@(posedge mclk_i) disable iff (!rst_n_i)
    (pad_oen_i[NUM_PWM-1:0] & pwm_en_i) == '0)
  else begin
    $error("PWM-enabled pad has output enable off");
    assert_fails++;
  end

endmodule

bind pinmux_top pinmux_asserts #(.NUM_PINS(NUM_PINS), .NUM_PWM(NUM_PWM)) u_asserts (
  .mclk_i    (mclk_i),
  .rst_n_i   (rst_n_i),
  .wb_i      (wb_i),
  .wb_o      (wb_o),
  .pad_oen_i (pad_oen_o),
  .pwm_en_i  (pwm_en)
);

// File: tests/tb_pinmux.sv
`timescale 1ns/1ps

module tb_pinmux;

  import pinmux_pkg::*;

  localparam int NUM_PINS   = 16;
  localparam int NUM_PWM    = 4;
  localparam int US_PER_MS  = 4;
  localparam int CLK_PERIOD = 40;
  // PWM test setup
  localparam int PWM_CH     = 1;
  localparam int PWM_HIGH   = 3;
  localparam int PWM_LOW    = 2;
  localparam int PULSE_CFG  = 2;
  localparam int HIGH_CYC   = PWM_HIGH * (PULSE_CFG + 1) * US_PER_MS;
  localparam int LOW_CYC    = PWM_LOW * (PULSE_CFG + 1) * US_PER_MS;
  // Run length: 3 PWM periods, bus traffic, pad waits, margin
  localparam int PWM_CYCLES = 3 * (HIGH_CYC + LOW_CYC);
  localparam int BUS_OPS    = 150;
  localparam int WDOG_NS    = (PWM_CYCLES + BUS_OPS * 4 + 500) * CLK_PERIOD;

  logic                mclk;
  logic                rst_n;
  wb_req_t             wb_req;
  wb_rsp_t             wb_rsp;
  logic [NUM_PINS-1:0] pad_in;
  logic [NUM_PINS-1:0] pad_out;
  logic [NUM_PINS-1:0] pad_oen;
  logic                irq;

  // Register model
  logic [31:0]         m_dir;
  logic [31:0]         m_out;
  logic [NUM_PINS-1:0] m_pad;
  logic [NUM_PINS-1:0] m_pos;
  logic [NUM_PINS-1:0] m_neg;
  logic [NUM_PINS-1:0] m_stat;
  logic [NUM_PWM-1:0]  m_pwm_en;
  logic [PULSE_W-1:0]  m_pulse;
  logic [31:0]         m_pwm [NUM_PWM];

  // Compare handshake
  string               chk_name;
  logic [31:0]         chk_exp;
  logic [31:0]         chk_act;
  event                chk_req;
  event                chk_done;

  int                  seed = 95229;

  pinmux_top #(
    .NUM_PINS  (NUM_PINS),
    .NUM_PWM   (NUM_PWM),
    .US_PER_MS (US_PER_MS)
  ) UUT (
    .mclk_i    (mclk),
    .rst_n_i   (rst_n),
    .wb_i      (wb_req),
    .wb_o      (wb_rsp),
    .pad_in_i  (pad_in),
    .pad_out_o (pad_out),
    .pad_oen_o (pad_oen),
    .irq_o     (irq)
  );

  always #(CLK_PERIOD / 2) mclk = ~mclk;

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] byte_merge(input logic [31:0] old, input logic [31:0] dat,
                                             input logic [3:0] sel);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = dat[8*b +: 8];
    end
    return res;
  endfunction

  // Expected read data for one word address
  function automatic logic [31:0] model_read(input logic [3:0] adr);
    case (adr)
      4'd0: return m_dir;
      4'd1: return m_out;
      4'd2: return 32'(m_pad);
      4'd3: return 32'(m_pos);
      4'd4: return 32'(m_neg);
      4'd5: return 32'(m_stat);
      4'd6: return 32'(m_pwm_en);
      4'd7: return 32'(m_pulse);
      default: begin
        if (adr >= 4'd8 && adr < 4'(8 + NUM_PWM)) return m_pwm[adr - 4'd8];
        return 32'h0;
      end
    endcase
  endfunction

  // Expected {oen, out} from the mux rule
  function automatic logic [31:0] predict_pads(input logic [NUM_PWM-1:0] wave);
    logic [NUM_PINS-1:0] out;
    logic [NUM_PINS-1:0] oen;
    for (int i = 0; i < NUM_PINS; i++) begin
      if (i < NUM_PWM && m_pwm_en[i]) begin
        out[i] = wave[i];
        oen[i] = 1'b0;
      end else if (m_dir[i]) begin
        out[i] = m_out[i];
        oen[i] = 1'b0;
      end else begin
        out[i] = 1'b0;
        oen[i] = 1'b1;
      end
    end
    return {oen, out};
  endfunction

  task automatic model_write(input logic [3:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
    logic [31:0] mask;
    mask = byte_merge('0, '1, sel);
    case (adr)
      4'd0: m_dir    = byte_merge(m_dir, dat, sel);
      4'd1: m_out    = byte_merge(m_out, dat, sel);
      4'd3: m_pos    = NUM_PINS'(byte_merge(32'(m_pos), dat, sel));
      4'd4: m_neg    = NUM_PINS'(byte_merge(32'(m_neg), dat, sel));
      4'd5: m_stat   = m_stat & ~NUM_PINS'(dat & mask);
      4'd6: m_pwm_en = NUM_PWM'(byte_merge(32'(m_pwm_en), dat, sel));
      4'd7: m_pulse  = PULSE_W'(byte_merge(32'(m_pulse), dat, sel));
      default: begin
        if (adr >= 4'd8 && adr < 4'(8 + NUM_PWM)) begin
          m_pwm[adr - 4'd8] = byte_merge(m_pwm[adr - 4'd8], dat, sel);
        end
      end
    endcase
  endtask

  // --------------------------------------------------------------------------
  // Compare process
  // --------------------------------------------------------------------------
  always begin
    @(chk_req);
    assert (chk_exp === chk_act) begin
      -> chk_done;
    end else begin
      $display("[ERROR] %s expected %h actual %h", chk_name, chk_exp, chk_act);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    chk_name = name;
    chk_exp  = exp;
    chk_act  = act;
    -> chk_req;
    @(chk_done);
  endtask

  // --------------------------------------------------------------------------
  // Wishbone master
  // --------------------------------------------------------------------------
  // Holds the request until ack, data sampled mid-cycle
  task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic [31:0] rdat);
    wb_req_t req;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    req.sel = sel;
    @(posedge mclk);
    wb_req <= req;
    do @(negedge mclk); while (!wb_rsp.ack);
    rdat = wb_rsp.dat;
    @(posedge mclk);
    wb_req <= '0;
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, sel, unused);
    model_write(adr, dat, sel);
  endtask

  task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, '0, 4'hf, dat);
  endtask

  task automatic read_check(input string name, input logic [3:0] adr);
    logic [31:0] dat;
    wb_read(adr, dat);
    check_value(name, model_read(adr), dat);
  endtask

  task automatic pads_check(input string name, input logic [NUM_PWM-1:0] wave);
    @(negedge mclk);
    check_value(name, predict_pads(wave), {pad_oen, pad_out});
  endtask

  task automatic drive_pads(input logic [NUM_PINS-1:0] val);
    @(posedge mclk);
    pad_in <= val;
  endtask

  // Counts cycles until the PWM pad shows the given level
  task automatic cycles_until(input logic level, output int cycles);
    cycles = 0;
    do begin
      @(negedge mclk);
      cycles++;
    end while (pad_out[PWM_CH] !== level);
  endtask

  // --------------------------------------------------------------------------
  // Watchdog
  // --------------------------------------------------------------------------
  initial begin
    #(WDOG_NS);
    $display("Watchdog expired: the tests did not finish in the expected time");
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0]         dat;
    logic [3:0]          adr;
    logic [3:0]          sel;
    logic [NUM_PINS-1:0] val;
    int                  hi;
    int                  lo;
    mclk     = 1'b0;
    rst_n    = 1'b0;
    wb_req   = '0;
    pad_in   = '0;
    m_dir    = '0;
    m_out    = '0;
    m_pad    = '0;
    m_pos    = '0;
    m_neg    = '0;
    m_stat   = '0;
    m_pwm_en = '0;
    m_pulse  = '0;
    for (int k = 0; k < NUM_PWM; k++) m_pwm[k] = '0;
    repeat (3) @(posedge mclk);
    rst_n <= 1'b1;

    // Reset values
    for (int a = 0; a < 16; a++) read_check("reset_regs", 4'(a));
    pads_check("reset_pads", '0);
    check_value("reset_irq", 32'h0, 32'(irq));

    // Random GPIO writes with byte lanes
    for (int i = 0; i < 16; i++) begin
      adr = 4'($random(seed) & 1);
      sel = 4'($random(seed));
      dat = $random(seed);
      wb_write(adr, dat, sel);
      read_check("gpio_rw", adr);
    end
    pads_check("gpio_pads", '0);

    // Pad read-back through the synchronizer
    for (int i = 0; i < 4; i++) begin
      val = NUM_PINS'($random(seed));
      drive_pads(val);
      m_pad = val;
      repeat (3) @(posedge mclk);
      read_check("gpio_in", 4'd2);
    end

    // Edge interrupts, rising on the low byte and falling on the high byte
    wb_write(4'd3, 32'h0000_00ff, 4'hf);
    wb_write(4'd4, 32'h0000_ff00, 4'hf);
    for (int i = 0; i < 2; i++) begin
      val = m_pad ^ (NUM_PINS'($random(seed)) | 16'h0101);
      drive_pads(val);
      m_stat = m_stat | (val & ~m_pad & m_pos) | (~val & m_pad & m_neg);
      m_pad  = val;
      repeat (5) @(posedge mclk);
      read_check("int_stat_set", 4'd5);
      @(negedge mclk);
      check_value("int_irq_set", 32'(|m_stat), 32'(irq));
      wb_write(4'd5, 32'(m_stat), 4'hf);
      read_check("int_stat_clear", 4'd5);
      @(negedge mclk);
      check_value("int_irq_clear", 32'h0, 32'(irq));
    end

    // PWM channel takes over its pad
    wb_write(4'd7, 32'(PULSE_CFG), 4'hf);
    wb_write(4'(8 + PWM_CH), {16'(PWM_HIGH), 16'(PWM_LOW)}, 4'hf);
    wb_write(4'd6, 32'(1 << PWM_CH), 4'hf);
    // Channel starts in its high phase and owns the pad
    pads_check("pwm_pads", NUM_PWM'(1 << PWM_CH));
    // Skip the partial first high phase
    cycles_until(1'b1, hi);
    cycles_until(1'b0, hi);
    cycles_until(1'b1, lo);
    cycles_until(1'b0, hi);
    cycles_until(1'b1, lo);
    check_value("pwm_high_cycles", 32'(HIGH_CYC), 32'(hi));
    check_value("pwm_low_cycles", 32'(LOW_CYC), 32'(lo));
    wb_write(4'd6, 32'h0, 4'hf);
    pads_check("pwm_off_pads", '0);

    // Unmapped word
    dat = $random(seed);
    wb_write(4'd13, dat, 4'hf);
    read_check("unmapped_read", 4'd13);
    for (int a = 0; a < 8 + NUM_PWM; a++) read_check("unmapped_no_side_effect", 4'(a));

    repeat (2) @(posedge mclk);
    if (UUT.u_asserts.assert_fails == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("Concurrent assertions failed %0d times", UUT.u_asserts.assert_fails);
      $display("TB FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule
